// File: Makefile
# Verilator build and run for the UART byte-flip agent

VERILATOR ?= verilator
TOP       ?= tb_uart_flip
RTL_TOP   ?= uart_flip_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= --timescale 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(TIMESCALE) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass message shows up as a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/byte_flip_core.sv
`include "uart_flip_settings.svh"

module byte_flip_core (
    input  logic                    avm_clk,
    input  logic                    avm_rst,
    input  logic                    start,
    input  logic [`UART_BYTE_W-1:0] data_in,
    output logic [`UART_BYTE_W-1:0] data_out,
    output logic                    done
);
    import uart_flip_pkg::*;

    localparam int CNT_W = $clog2(`UART_BYTE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`UART_BYTE_W - 1);

    flip_state_t             state_r;
    logic [CNT_W-1:0]        cnt_r;
    logic                    done_r;
    logic [`UART_BYTE_W-1:0] in_sr;
    logic [`UART_BYTE_W-1:0] out_sr;
    logic [`UART_BYTE_W-1:0] src;
    logic                    load;
    logic                    shift;

    assign load  = (state_r == FLIP_IDLE) && start;
    assign shift = (state_r == FLIP_SHIFT);

    // The first bit moves on the load edge, so the last lands eight cycles after start
    assign src = load ? data_in : in_sr;

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state_r <= FLIP_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                FLIP_IDLE: begin
                    if (start) begin
                        state_r <= FLIP_SHIFT;
                        cnt_r   <= CNT_W'(1);
                    end
                end
                FLIP_SHIFT: begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == LAST_BIT) begin
                        done_r  <= 1'b1;
                        state_r <= FLIP_IDLE;
                    end
                end
                default: begin
                    state_r <= FLIP_IDLE;
                end
            endcase
        end
    end

    // LSB of the input goes in at the bottom of the output, which ends up reversed
    always_ff @(posedge avm_clk) begin
        if (load || shift) begin
            in_sr  <= src >> 1;
            out_sr <= {out_sr[`UART_BYTE_W-2:0], src[0]};
        end
    end

    assign data_out = out_sr;
    assign done     = done_r;

endmodule

// File: rtl/uart_flip_pkg.sv
`include "uart_flip_settings.svh"

package uart_flip_pkg;

    // One Avalon-MM master request, split into ports at the top level
    typedef struct packed {
        logic [`UART_ADDR_W-1:0] address;
        logic                    read;
        logic                    write;
        logic [`UART_DATA_W-1:0] writedata;
    } avm_req_t;

    // Request driven while the master is in reset
    localparam avm_req_t AVM_REQ_IDLE = '{
        address:   `UART_STATUS_ADDR,
        read:      1'b0,
        write:     1'b0,
        writedata: '0
    };

    // Bus master sequence
    // POLL_RX_STATUS waits for a received byte and POLL_TX_STATUS for a free transmitter
    typedef enum logic [2:0] {
        POLL_RX_STATUS = 3'd0,
        READ_RX        = 3'd1,
        WAIT_CORE      = 3'd2,
        POLL_TX_STATUS = 3'd3,
        WRITE_TX       = 3'd4
    } poll_state_t;

    // Compute core states
    typedef enum logic {
        FLIP_IDLE  = 1'b0,
        FLIP_SHIFT = 1'b1
    } flip_state_t;

endpackage

// File: rtl/uart_flip_settings.svh
`ifndef UART_FLIP_SETTINGS_SVH
`define UART_FLIP_SETTINGS_SVH

// Bus and payload widths of the UART register block
`define UART_ADDR_W 5
`define UART_DATA_W 32
`define UART_BYTE_W 8

// Register byte offsets
`define UART_RX_ADDR     5'd0
`define UART_TX_ADDR     5'd4
`define UART_STATUS_ADDR 5'd8

// Status register bits
`define UART_TX_OK_BIT 6
`define UART_RX_OK_BIT 7

`endif

// File: rtl/uart_flip_top.sv
`include "uart_flip_settings.svh"

module uart_flip_top (
    input  logic                    avm_clk,
    input  logic                    avm_rst,
    output logic [`UART_ADDR_W-1:0] avm_address,
    output logic                    avm_read,
    output logic                    avm_write,
    output logic [`UART_DATA_W-1:0] avm_writedata,
    input  logic [`UART_DATA_W-1:0] avm_readdata,
    input  logic                    avm_waitrequest
);
    import uart_flip_pkg::*;

    avm_req_t                req;
    logic                    flip_start;
    logic [`UART_BYTE_W-1:0] flip_in;
    logic [`UART_BYTE_W-1:0] flip_out;
    logic                    flip_done;

    // Avalon master port
    assign avm_address   = req.address;
    assign avm_read      = req.read;
    assign avm_write     = req.write;
    assign avm_writedata = req.writedata;

    uart_poll_master master_i (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .req         (req),
        .readdata    (avm_readdata),
        .waitrequest (avm_waitrequest),
        .flip_start  (flip_start),
        .flip_in     (flip_in),
        .flip_out    (flip_out),
        .flip_done   (flip_done)
    );

    // Bit reversal takes eight cycles from start to done
    byte_flip_core core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (flip_start),
        .data_in  (flip_in),
        .data_out (flip_out),
        .done     (flip_done)
    );

endmodule

// File: rtl/uart_poll_master.sv
`include "uart_flip_settings.svh"

module uart_poll_master (
    input  logic                     avm_clk,
    input  logic                     avm_rst,
    output uart_flip_pkg::avm_req_t  req,
    input  logic [`UART_DATA_W-1:0]  readdata,
    input  logic                     waitrequest,
    output logic                     flip_start,
    output logic [`UART_BYTE_W-1:0]  flip_in,
    input  logic [`UART_BYTE_W-1:0]  flip_out,
    input  logic                     flip_done
);
    import uart_flip_pkg::*;

    localparam int PAD_W = `UART_DATA_W - `UART_BYTE_W;

    poll_state_t state_r;
    poll_state_t state_nxt;

    // All bus outputs come straight from this register
    avm_req_t req_r;
    avm_req_t req_nxt;

    logic                    start_r;
    logic                    start_nxt;
    logic [`UART_BYTE_W-1:0] rx_byte_r;

    logic xfer_done;
    logic rx_ok;
    logic tx_ok;

    // A transfer ends on the edge where a command is up and waitrequest is low
    assign xfer_done = (req_r.read || req_r.write) && !waitrequest;

    assign rx_ok = readdata[`UART_RX_OK_BIT];
    assign tx_ok = readdata[`UART_TX_OK_BIT];

    always_comb begin
        state_nxt = state_r;
        req_nxt   = req_r;
        start_nxt = 1'b0;

        case (state_r)
            POLL_RX_STATUS: begin
                // Also raises the first status read after reset
                req_nxt.read    = 1'b1;
                req_nxt.write   = 1'b0;
                req_nxt.address = `UART_STATUS_ADDR;
                if (xfer_done && rx_ok) begin
                    req_nxt.address = `UART_RX_ADDR;
                    state_nxt       = READ_RX;
                end
            end

            READ_RX: begin
                if (xfer_done) begin
                    req_nxt.read = 1'b0;
                    start_nxt    = 1'b1;
                    state_nxt    = WAIT_CORE;
                end
            end

            WAIT_CORE: begin
                // Result stays in writedata until the TX write is accepted
                if (flip_done) begin
                    req_nxt.read      = 1'b1;
                    req_nxt.address   = `UART_STATUS_ADDR;
                    req_nxt.writedata = {{PAD_W{1'b0}}, flip_out};
                    state_nxt         = POLL_TX_STATUS;
                end
            end

            POLL_TX_STATUS: begin
                if (xfer_done && tx_ok) begin
                    req_nxt.read    = 1'b0;
                    req_nxt.write   = 1'b1;
                    req_nxt.address = `UART_TX_ADDR;
                    state_nxt       = WRITE_TX;
                end
            end

            WRITE_TX: begin
                if (xfer_done) begin
                    req_nxt.write   = 1'b0;
                    req_nxt.read    = 1'b1;
                    req_nxt.address = `UART_STATUS_ADDR;
                    state_nxt       = POLL_RX_STATUS;
                end
            end

            default: begin
                req_nxt   = AVM_REQ_IDLE;
                state_nxt = POLL_RX_STATUS;
            end
        endcase
    end

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state_r <= POLL_RX_STATUS;
            req_r   <= AVM_REQ_IDLE;
            start_r <= 1'b0;
        end else begin
            state_r <= state_nxt;
            req_r   <= req_nxt;
            start_r <= start_nxt;
        end
    end

    // Received byte, held for the core while it loads
    always_ff @(posedge avm_clk) begin
        if (state_r == READ_RX && xfer_done) begin
            rx_byte_r <= readdata[`UART_BYTE_W-1:0];
        end
    end

    assign req        = req_r;
    assign flip_start = start_r;
    assign flip_in    = rx_byte_r;

endmodule

// File: testbench/tb_uart_flip.sv
`include "uart_flip_settings.svh"

module tb_uart_flip;
    timeunit 1ns;
    timeprecision 100ps;

    import uart_flip_pkg::*;

    localparam int BW          = `UART_BYTE_W;
    localparam int CLK_PERIOD  = 4;
    localparam int NUM_BYTES   = 21;
    localparam int BYTE_BUDGET = 64;
    localparam int MARGIN      = 1500;
    localparam int WATCHDOG_NS = (NUM_BYTES * BYTE_BUDGET + MARGIN) * CLK_PERIOD;
    localparam int SETTLE      = 30;

    logic                    avm_clk;
    logic                    avm_rst;
    logic [`UART_ADDR_W-1:0] avm_address;
    logic                    avm_read;
    logic                    avm_write;
    logic [`UART_DATA_W-1:0] avm_writedata;
    logic [`UART_DATA_W-1:0] avm_readdata;
    logic                    avm_waitrequest;
    logic                    rx_push;
    logic [BW-1:0]           rx_data;
    logic                    tx_ready;
    logic [3:0]              stall_cycles = '0;
    logic                    rand_stall;
    logic [3:0]              fixed_stall;
    logic [7:0]              lfsr;
    logic [7:0]              stall_lfsr;
    avm_req_t                idle_req;
    int                      errors;
    int                      checks;
    int                      tests_run;
    int                      tests_failed;

    uart_flip_top dut_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest)
    );

    uart_reg_model model_i (
        .avm_clk      (avm_clk),
        .avm_rst      (avm_rst),
        .address      (avm_address),
        .read         (avm_read),
        .write        (avm_write),
        .writedata    (avm_writedata),
        .readdata     (avm_readdata),
        .waitrequest  (avm_waitrequest),
        .rx_push      (rx_push),
        .rx_data      (rx_data),
        .tx_ready     (tx_ready),
        .stall_cycles (stall_cycles)
    );

    always #(CLK_PERIOD / 2) avm_clk = ~avm_clk;

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        logic [7:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 8'hB8;
        end
        return n;
    endfunction

    function automatic logic [BW-1:0] rand_bits(input int n);
        logic [BW-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[BW-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // Output bit i is input bit BW-1-i
    function automatic logic [BW-1:0] reverse_byte(input logic [BW-1:0] b);
        logic [BW-1:0] r;
        for (int i = 0; i < BW; i++) begin
            r[i] = b[BW-1-i];
        end
        return r;
    endfunction

    function automatic avm_req_t bus_req();
        avm_req_t r;
        r.address   = avm_address;
        r.read      = avm_read;
        r.write     = avm_write;
        r.writedata = avm_writedata;
        return r;
    endfunction

    task automatic report_error(input string msg);
        $display("error %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_byte(input logic [BW-1:0] got, input logic [BW-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
        end
    endtask

    task automatic check_req(input avm_req_t got, input avm_req_t exp, input string what);
        checks++;
        if (got !== exp) begin
            report_error($sformatf(
                "%s: got addr %0d rd %b wr %b data 0x%08h, expected %0d %b %b 0x%08h",
                what, got.address, got.read, got.write, got.writedata,
                exp.address, exp.read, exp.write, exp.writedata));
        end
    endtask

    // Random stalls take two LFSR bits per cycle, fixed stalls otherwise
    always @(negedge avm_clk) begin
        if (rand_stall) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            stall_cycles[0] = stall_lfsr[0];
            stall_lfsr = lfsr_next(stall_lfsr);
            stall_cycles[1] = stall_lfsr[0];
            stall_cycles[3:2] = 2'b00;
        end else begin
            stall_cycles = fixed_stall;
        end
        if (avm_rst && avm_read && avm_write) begin
            report_error("read and write high together");
        end
    end

    task automatic push_rx(input logic [BW-1:0] b);
        rx_data = b;
        rx_push = 1'b1;
        @(negedge avm_clk);
        rx_push = 1'b0;
    endtask

    task automatic wait_tx_count(input int target, input int limit);
        int n;
        n = 0;
        while (model_i.tx_count() < target && n < limit) begin
            @(negedge avm_clk);
            n++;
        end
        if (model_i.tx_count() < target) begin
            $display("timeout: TX write %0d did not arrive within %0d cycles", target, limit);
            errors++;
        end
    endtask

    task automatic wait_state(input poll_state_t s, input int limit);
        int n;
        n = 0;
        while (dut_i.master_i.state_r != s && n < limit) begin
            @(negedge avm_clk);
            n++;
        end
        if (dut_i.master_i.state_r != s) begin
            $display("timeout: master never reached state %s", s.name());
            errors++;
        end
    endtask

    task automatic expect_writes(input int base, input int n, input string what);
        checks++;
        if (model_i.tx_count() != base + n) begin
            report_error($sformatf("%s: expected %0d TX writes, saw %0d",
                what, n, model_i.tx_count() - base));
        end
    endtask

    task automatic send_and_check(input logic [BW-1:0] b, input string what);
        int base;
        base = model_i.tx_count();
        push_rx(b);
        wait_tx_count(base + 1, BYTE_BUDGET);
        repeat (SETTLE) @(negedge avm_clk);
        expect_writes(base, 1, what);
        if (model_i.tx_count() > base) begin
            check_byte(model_i.tx_byte(base), reverse_byte(b), what);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d mismatches", name, errors - err_before);
        end
    endtask

    task automatic test_single_byte();
        int e;
        e = errors;
        send_and_check(rand_bits(BW), "single byte");
        finish_test("single_byte", e);
    endtask

    task automatic test_empty_rx();
        int e;
        int base;
        int status_reads;
        e = errors;
        base = model_i.tx_count();
        status_reads = 0;
        repeat (100) begin
            @(negedge avm_clk);
            if (avm_write) begin
                report_error("write issued while RX is empty");
            end
            if (avm_read && avm_address != `UART_STATUS_ADDR) begin
                report_error($sformatf("read at address %0d while RX is empty", avm_address));
            end
            if (avm_read && avm_address == `UART_STATUS_ADDR) begin
                status_reads++;
            end
        end
        expect_writes(base, 0, "empty RX");
        checks++;
        if (status_reads == 0) begin
            report_error("no status read seen while RX is empty");
        end
        finish_test("empty_rx", e);
    endtask

    task automatic test_tx_hold();
        int e;
        int base;
        logic [BW-1:0] b;
        e = errors;
        b = rand_bits(BW);
        tx_ready = 1'b0;
        base = model_i.tx_count();
        push_rx(b);
        wait_state(POLL_TX_STATUS, BYTE_BUDGET);
        repeat (60) begin
            @(negedge avm_clk);
            if (avm_write) begin
                report_error("TX write issued while the transmitter is busy");
            end
        end
        expect_writes(base, 0, "TX held");
        tx_ready = 1'b1;
        wait_tx_count(base + 1, BYTE_BUDGET);
        repeat (SETTLE) @(negedge avm_clk);
        expect_writes(base, 1, "TX released");
        if (model_i.tx_count() > base) begin
            check_byte(model_i.tx_byte(base), reverse_byte(b), "TX released");
        end
        finish_test("tx_hold", e);
    endtask

    task automatic test_random_stalls();
        int e;
        logic [BW-1:0] b;
        e = errors;
        b = rand_bits(BW);
        rand_stall <= 1'b1;
        send_and_check(b, "random stalls");
        rand_stall <= 1'b0;
        finish_test("random_stalls", e);
    endtask

    task automatic test_stream();
        int e;
        int base;
        logic [BW-1:0] sent[16];
        e = errors;
        fixed_stall <= 4'd1;
        base = model_i.tx_count();
        for (int i = 0; i < 16; i++) begin
            sent[i] = rand_bits(BW);
            push_rx(sent[i]);
        end
        wait_tx_count(base + 16, 16 * BYTE_BUDGET);
        repeat (SETTLE) @(negedge avm_clk);
        expect_writes(base, 16, "stream");
        for (int i = 0; i < 16; i++) begin
            if (model_i.tx_count() > base + i) begin
                check_byte(model_i.tx_byte(base + i), reverse_byte(sent[i]),
                    $sformatf("stream byte %0d", i));
            end
        end
        fixed_stall <= 4'd0;
        finish_test("stream", e);
    endtask

    task automatic test_mid_reset();
        int e;
        int base;
        e = errors;
        base = model_i.tx_count();
        push_rx(rand_bits(BW));
        wait_state(WAIT_CORE, BYTE_BUDGET);
        repeat (3) @(negedge avm_clk);
        avm_rst = 1'b0;
        repeat (5) begin
            @(negedge avm_clk);
            check_req(bus_req(), idle_req, "request during reset");
        end
        avm_rst = 1'b1;
        // The byte caught in the reset is dropped
        repeat (40) @(negedge avm_clk);
        expect_writes(base, 0, "byte lost in reset");
        send_and_check(rand_bits(BW), "after reset");
        finish_test("mid_reset", e);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        avm_clk      = 1'b0;
        avm_rst      = 1'b0;
        rx_push      = 1'b0;
        rx_data      = '0;
        tx_ready     = 1'b1;
        rand_stall   = 1'b0;
        fixed_stall  = '0;
        lfsr         = 8'd79;
        stall_lfsr   = 8'd79;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        idle_req.address   = `UART_STATUS_ADDR;
        idle_req.read      = 1'b0;
        idle_req.write     = 1'b0;
        idle_req.writedata = '0;
        repeat (5) @(negedge avm_clk);
        avm_rst = 1'b1;
        test_single_byte();
        test_empty_rx();
        test_tx_hold();
        test_random_stalls();
        test_stream();
        test_mid_reset();
        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
            tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: testbench/uart_reg_model.sv
`include "uart_flip_settings.svh"

module uart_reg_model (
    input  logic                    avm_clk,
    input  logic                    avm_rst,
    input  logic [`UART_ADDR_W-1:0] address,
    input  logic                    read,
    input  logic                    write,
    input  logic [`UART_DATA_W-1:0] writedata,
    output logic [`UART_DATA_W-1:0] readdata,
    output logic                    waitrequest,
    input  logic                    rx_push,
    input  logic [`UART_BYTE_W-1:0] rx_data,
    input  logic                    tx_ready,
    input  logic [3:0]              stall_cycles
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`UART_BYTE_W-1:0] rx_q[$];
    logic [`UART_BYTE_W-1:0] tx_q[$];
    logic                    rx_avail = 1'b0;
    logic [`UART_BYTE_W-1:0] rx_head = '0;
    logic [3:0]              wait_cnt;
    logic                    xfer;

    // Each access is stalled for stall_cycles clocks before it is accepted
    assign waitrequest = (read || write) && (wait_cnt < stall_cycles);
    assign xfer        = (read || write) && !waitrequest;

    always_comb begin
        readdata = '0;
        case (address)
            `UART_STATUS_ADDR: begin
                readdata[`UART_RX_OK_BIT] = rx_avail;
                readdata[`UART_TX_OK_BIT] = tx_ready;
            end
            `UART_RX_ADDR: begin
                readdata[`UART_BYTE_W-1:0] = rx_head;
            end
            default: begin
                readdata = '0;
            end
        endcase
    end

    always @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            wait_cnt <= '0;
        end else if (waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // RX pops on an accepted RX read, TX collects every accepted write
    always @(posedge avm_clk) begin
        if (avm_rst && xfer && read && address == `UART_RX_ADDR && rx_q.size() != 0) begin
            void'(rx_q.pop_front());
        end
        if (avm_rst && xfer && write && address == `UART_TX_ADDR) begin
            tx_q.push_back(writedata[`UART_BYTE_W-1:0]);
        end
        if (rx_push) begin
            rx_q.push_back(rx_data);
        end
        rx_avail <= (rx_q.size() != 0);
        rx_head  <= (rx_q.size() != 0) ? rx_q[0] : '0;
    end

    function automatic int tx_count();
        return tx_q.size();
    endfunction

    function automatic logic [`UART_BYTE_W-1:0] tx_byte(input int idx);
        return tx_q[idx];
    endfunction

endmodule

// File: verilog.f
+incdir+rtl
rtl/uart_flip_pkg.sv
rtl/byte_flip_core.sv
rtl/uart_poll_master.sv
rtl/uart_flip_top.sv
testbench/uart_reg_model.sv
testbench/tb_uart_flip.sv
